// File: rtl/wb_pkg.sv
// Wishbone bus types and address map
`default_nettype none

package wb_pkg;

    // widths with a meaning on the bus
    typedef logic [31:0] wb_adr_t;  // byte address
    typedef logic [31:0] wb_dat_t;
    typedef logic [3:0]  wb_sel_t;  // one enable per byte lane
    typedef logic [2:0]  wb_tag_t;  // merged {tga, tgb, tgc}
    typedef logic [2:0]  wb_cti_t;
    typedef logic [1:0]  wb_bte_t;

    // master to slave request, classic cycle signals plus tags
    typedef struct packed {
        wb_adr_t adr;
        wb_dat_t dat;
        wb_sel_t sel;
        wb_tag_t tag;
        logic    we;
        logic    cyc;
        logic    stb;
        wb_cti_t cti;
        wb_bte_t bte;
    } wb_req_t;

    // slave to master response
    typedef struct packed {
        wb_dat_t dat;
        logic    ack;
        logic    err;
        logic    rty;   // carried only, no slave raises it
    } wb_rsp_t;

    // each RAM slave owns one 4 KiB window, slave k at k * span
    localparam int SLAVE_SPAN_LOG2 = 12;

endpackage

`default_nettype wire

// File: rtl/bus_arbiter.sv
// Round-robin bus arbiter
`default_nettype none

module bus_arbiter #(
    parameter int NUM_MASTERS = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [NUM_MASTERS-1:0] request_i,   // cyc of every master
    output logic [NUM_MASTERS-1:0] grant_o      // one-hot
);

    localparam int PTR_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

    logic [NUM_MASTERS-1:0] grant_q;
    logic [NUM_MASTERS-1:0] next_grant;
    logic [PTR_W-1:0]       last_q;     // index of the last owner
    logic [PTR_W-1:0]       next_last;
    logic                   owner_busy;

    // owner keeps the bus as long as its cyc stays high
    assign owner_busy = |(grant_q & request_i);

    // search starts just after the last owner
    always_comb begin
        int  idx;
        logic found;
        next_grant = '0;
        next_last  = last_q;
        found      = 1'b0;
        for (int i = 1; i <= NUM_MASTERS; i++) begin
            idx = (int'(last_q) + i) % NUM_MASTERS;
            if (!found && request_i[idx]) begin
                found           = 1'b1;
                next_grant[idx] = 1'b1;
                next_last       = PTR_W'(idx);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_q <= '0;
            last_q  <= PTR_W'(NUM_MASTERS - 1);  // master 0 wins first
        end else if (!owner_busy) begin
            grant_q <= next_grant;  // zero when nobody asks
            if (|next_grant) begin
                last_q <= next_last;
            end
        end
    end

    assign grant_o = grant_q;

endmodule

`default_nettype wire

// File: rtl/wb_slave_decoder.sv
// Slave address decoder with miss responder
`default_nettype none

module wb_slave_decoder #(
    parameter int NUM_RAMS = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  wb_pkg::wb_adr_t   adr_i,          // granted master address
    input  logic              stb_i,
    input  logic              cyc_i,
    output logic [NUM_RAMS:0] sel_onehot_o,   // top bit is the miss lane
    output wb_pkg::wb_rsp_t   miss_rsp_o
);

    import wb_pkg::*;

    wb_adr_t window;
    logic    miss;
    logic    err_q;

    assign window = adr_i >> SLAVE_SPAN_LOG2;

    // nothing mapped above the last RAM window
    assign miss = (window >= wb_adr_t'(NUM_RAMS));

    always_comb begin
        sel_onehot_o = '0;
        for (int k = 0; k < NUM_RAMS; k++) begin
            sel_onehot_o[k] = (window == wb_adr_t'(k));
        end
        sel_onehot_o[NUM_RAMS] = miss;
    end

    // one err pulse per strobed miss, cleared while the master drops stb
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            err_q <= 1'b0;
        end else begin
            err_q <= stb_i & cyc_i & miss & ~err_q;
        end
    end

    always_comb begin
        miss_rsp_o     = '0;
        miss_rsp_o.err = err_q;
    end

endmodule

`default_nettype wire

// File: rtl/wishbone_bus.sv
// Shared Wishbone bus
`default_nettype none

module wishbone_bus #(
    parameter int NUM_MASTERS = 3,
    parameter int NUM_SLAVES  = 4
) (
    input  logic                  clk,
    input  logic                  reset,

    // master side
    input  wb_pkg::wb_req_t       m_req_i [NUM_MASTERS],
    output wb_pkg::wb_rsp_t       m_rsp_o [NUM_MASTERS],

    // slave side, one request shared by all lanes
    output wb_pkg::wb_req_t       s_req_o,
    output logic [NUM_SLAVES-1:0] s_stb_o,
    input  wb_pkg::wb_rsp_t       s_rsp_i [NUM_SLAVES],

    // address decode loop
    input  logic [NUM_SLAVES-1:0] s_sel_onehot_i,
    output wb_pkg::wb_adr_t       grant_adr_o
);

    import wb_pkg::*;

    logic [NUM_MASTERS-1:0] m_cyc;
    logic [NUM_MASTERS-1:0] grant;
    wb_req_t                granted;
    wb_rsp_t                bus_rsp;

    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_cyc[m] = m_req_i[m].cyc;
        end
    end

    generate
        if (NUM_MASTERS > 1) begin : g_arb
            bus_arbiter #(
                .NUM_MASTERS (NUM_MASTERS)
            ) bus_arbiter_i (
                .clk       (clk),
                .reset     (reset),
                .request_i (m_cyc),
                .grant_o   (grant)
            );
        end else begin : g_single
            assign grant = m_cyc;   // lone master owns the bus while in a cycle
        end
    endgenerate

    // and-or mux, an empty grant leaves cyc and stb low
    always_comb begin
        granted = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (grant[m]) begin
                granted = granted | m_req_i[m];
            end
        end
    end

    assign s_req_o     = granted;
    assign grant_adr_o = granted.adr;
    assign s_stb_o     = s_sel_onehot_i & {NUM_SLAVES{granted.stb & granted.cyc}};

    // handshakes are ored, read data follows the select
    always_comb begin
        bus_rsp = '0;
        for (int k = 0; k < NUM_SLAVES; k++) begin
            bus_rsp.ack = bus_rsp.ack | s_rsp_i[k].ack;
            bus_rsp.err = bus_rsp.err | s_rsp_i[k].err;
            bus_rsp.rty = bus_rsp.rty | s_rsp_i[k].rty;
            if (s_sel_onehot_i[k]) begin
                bus_rsp.dat = bus_rsp.dat | s_rsp_i[k].dat;
            end
        end
    end

    // only the owner sees a response
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_rsp_o[m] = grant[m] ? bus_rsp : '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/wb_ram_slave.sv
// Wishbone RAM slave with wait states
`default_nettype none

module wb_ram_slave #(
    parameter int RAM_WORDS_LOG2 = 6,
    parameter int WAIT_STATES    = 0
) (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_req_t req_i,
    input  logic            stb_i,    // already gated by the decoder select
    output wb_pkg::wb_rsp_t rsp_o
);

    import wb_pkg::*;

    localparam int CNT_W     = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam int NUM_BYTES = $bits(wb_sel_t);
    localparam int WORD_LSB  = $clog2(NUM_BYTES);

    wb_dat_t mem [2**RAM_WORDS_LOG2];
    wb_dat_t rd_dat_q;

    logic [RAM_WORDS_LOG2-1:0] word_idx;
    logic [CNT_W-1:0]          cnt_q;
    logic                      ack_q;
    logic                      active;
    logic                      done;

    assign word_idx = req_i.adr[RAM_WORDS_LOG2+WORD_LSB-1:WORD_LSB];

    // no new access while ack is out, master drops stb next cycle
    assign active = stb_i & req_i.cyc & ~ack_q;
    assign done   = active & (cnt_q == CNT_W'(WAIT_STATES));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= done;
            if (active && !done) begin
                cnt_q <= cnt_q + 1'b1;  // still waiting
            end else begin
                cnt_q <= '0;
            end
        end
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (done) begin
            if (req_i.we) begin
                for (int b = 0; b < NUM_BYTES; b++) begin
                    if (req_i.sel[b]) begin
                        mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end
            rd_dat_q <= mem[word_idx];
        end
    end

    always_comb begin
        rsp_o     = '0;
        rsp_o.dat = rd_dat_q;
        rsp_o.ack = ack_q;
    end

endmodule

`default_nettype wire

// File: rtl/wb_soc.sv
// Shared-bus SoC fabric top level
`default_nettype none

module wb_soc #(
    parameter int NUM_MASTERS    = 3,
    parameter int NUM_RAMS       = 3,
    parameter int RAM_WORDS_LOG2 = 6
) (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_req_t m_req_i [NUM_MASTERS],
    output wb_pkg::wb_rsp_t m_rsp_o [NUM_MASTERS]
);

    import wb_pkg::*;

    // RAM lanes first, the miss responder last
    localparam int NUM_SLAVES = NUM_RAMS + 1;

    wb_req_t               s_req;
    logic [NUM_SLAVES-1:0] s_stb;
    wb_rsp_t               s_rsp [NUM_SLAVES];
    logic [NUM_SLAVES-1:0] sel_onehot;
    wb_adr_t               grant_adr;

    wishbone_bus #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES)
    ) wishbone_bus_i (
        .clk            (clk),
        .reset          (reset),
        .m_req_i        (m_req_i),
        .m_rsp_o        (m_rsp_o),
        .s_req_o        (s_req),
        .s_stb_o        (s_stb),
        .s_rsp_i        (s_rsp),
        .s_sel_onehot_i (sel_onehot),
        .grant_adr_o    (grant_adr)
    );

    wb_slave_decoder #(
        .NUM_RAMS (NUM_RAMS)
    ) wb_slave_decoder_i (
        .clk          (clk),
        .reset        (reset),
        .adr_i        (grant_adr),
        .stb_i        (s_stb[NUM_RAMS]),   // miss lane strobe
        .cyc_i        (s_req.cyc),
        .sel_onehot_o (sel_onehot),
        .miss_rsp_o   (s_rsp[NUM_RAMS])
    );

    // RAM k answers with k wait states
    generate
        for (genvar k = 0; k < NUM_RAMS; k++) begin : g_ram
            wb_ram_slave #(
                .RAM_WORDS_LOG2 (RAM_WORDS_LOG2),
                .WAIT_STATES    (k)
            ) wb_ram_slave_i (
                .clk   (clk),
                .reset (reset),
                .req_i (s_req),
                .stb_i (s_stb[k]),
                .rsp_o (s_rsp[k])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: sim/tb_wb_soc.sv
// Wishbone SoC fabric testbench
`default_nettype none

module tb_wb_soc;

    import wb_pkg::*;

    localparam int NUM_MASTERS    = 3;
    localparam int NUM_RAMS       = 3;
    localparam int RAM_WORDS_LOG2 = 6;
    localparam int MAX_TX         = 64;
    localparam int RESET_CYCLES   = 10;

    logic    clk;
    logic    reset;
    wb_req_t m_req [NUM_MASTERS];
    wb_rsp_t m_rsp [NUM_MASTERS];

    // transaction list as read from the data file
    int      tx_group  [MAX_TX];
    int      tx_master [MAX_TX];
    logic    tx_we     [MAX_TX];
    wb_adr_t tx_adr    [MAX_TX];
    wb_dat_t tx_dat    [MAX_TX];
    wb_sel_t tx_sel    [MAX_TX];
    logic    tx_err    [MAX_TX];
    int      n_tx;
    bit      loaded;

    wb_dat_t     ref_mem [wb_adr_t];   // keyed by word address
    logic [31:0] lfsr_q;
    int          n_checks;
    int          n_errors;
    int          wins [NUM_MASTERS][NUM_MASTERS];  // completions of m while n waits

    wb_soc #(
        .NUM_MASTERS    (NUM_MASTERS),
        .NUM_RAMS       (NUM_RAMS),
        .RAM_WORDS_LOG2 (RAM_WORDS_LOG2)
    ) wb_soc_i (
        .clk     (clk),
        .reset   (reset),
        .m_req_i (m_req),
        .m_rsp_o (m_rsp)
    );

    always #4 clk = ~clk;

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = (value << 1) | int'(lfsr_q[0]);
        end
    endtask

    task automatic report_problem(input string msg);
        n_checks++;
        n_errors++;
        $display("%s", msg);
    endtask

    task automatic check_dat(input string name, input wb_dat_t got, input wb_dat_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    // status is {ack, err, rty}
    task automatic check_status(input string name, input wb_rsp_t got, input logic [2:0] exp);
        logic [2:0] st;
        st = {got.ack, got.err, got.rty};
        n_checks++;
        if (st !== exp) begin
            n_errors++;
            $display("ERR %s status got %h exp %h", name, st, exp);
        end
    endtask

    task automatic load_testdata();
        int    fd;
        int    cnt;
        int    we;
        int    err;
        bit    eof;
        string line;
        fd   = $fopen("sim/wb_soc_testdata.txt", "r");
        n_tx = 0;
        eof  = 0;
        if (fd == 0) begin
            report_problem("could not open sim/wb_soc_testdata.txt");
        end else begin
            while (!eof) begin
                if ($fgets(line, fd) == 0) begin
                    eof = 1;
                end else if (line.len() > 1 && line[0] != 8'h23 && n_tx < MAX_TX) begin
                    cnt = $sscanf(line, "%d %d %d %h %h %h %d", tx_group[n_tx],
                                  tx_master[n_tx], we, tx_adr[n_tx], tx_dat[n_tx],
                                  tx_sel[n_tx], err);
                    if (cnt == 7) begin
                        tx_we[n_tx]  = (we != 0);
                        tx_err[n_tx] = (err != 0);
                        n_tx++;
                    end
                end
            end
            $fclose(fd);
            if (n_tx == 0) begin
                report_problem("no transactions found in sim/wb_soc_testdata.txt");
            end
        end
    endtask

    task automatic ref_write(input wb_adr_t word, input wb_dat_t dat, input wb_sel_t sel);
        wb_dat_t cur;
        cur = ref_mem.exists(word) ? ref_mem[word] : 'x;
        for (int b = 0; b < $bits(wb_sel_t); b++) begin
            if (sel[b]) begin
                cur[8*b +: 8] = dat[8*b +: 8];
            end
        end
        ref_mem[word] = cur;
    endtask

    // plays every line of one group that belongs to master m
    task automatic run_master(input int m, input int grp);
        int      idle;
        wb_req_t req;
        wb_rsp_t rsp;
        wb_adr_t word;
        string   name;
        name = $sformatf("m_rsp_o[%0d]", m);
        for (int i = 0; i < n_tx; i++) begin
            if (tx_group[i] == grp && tx_master[i] == m) begin
                take_bits(2, idle);
                repeat (1 + idle) @(posedge clk);  // at least one idle cycle
                req     = '0;
                req.adr = tx_adr[i];
                req.dat = tx_dat[i];
                req.sel = tx_sel[i];
                req.tag = wb_tag_t'(m);
                req.we  = tx_we[i];
                req.cyc = 1'b1;
                req.stb = 1'b1;
                m_req[m] <= req;
                rsp = '0;
                while (!(rsp.ack || rsp.err)) begin
                    @(posedge clk);
                    rsp = m_rsp[m];
                end
                m_req[m] <= '0;
                word = tx_adr[i] >> 2;
                check_status(name, rsp, tx_err[i] ? 3'b010 : 3'b100);
                if (!tx_err[i] && rsp.ack) begin
                    if (tx_we[i]) begin
                        ref_write(word, tx_dat[i], tx_sel[i]);
                    end else if (!ref_mem.exists(word)) begin
                        report_problem($sformatf("read of unwritten address %h", tx_adr[i]));
                    end else begin
                        check_dat({name, ".dat"}, rsp.dat, ref_mem[word]);
                        check_dat({name, ".dat"}, rsp.dat, tx_dat[i]);
                    end
                end
            end
        end
    endtask

    // isolation, single pulse and fairness
    always @(posedge clk) begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if ((m_rsp[m].ack || m_rsp[m].err) && !(m_req[m].cyc && m_req[m].stb)) begin
                report_problem($sformatf("master %0d saw a response it never asked for", m));
            end
            if (m_rsp[m].ack && m_rsp[m].err) begin
                report_problem($sformatf("master %0d saw ack and err together", m));
            end
            if (m_rsp[m].rty) begin
                report_problem($sformatf("master %0d saw an unexpected retry", m));
            end
            if (m_rsp[m].ack || m_rsp[m].err) begin
                for (int n = 0; n < NUM_MASTERS; n++) begin
                    if (n != m && m_req[n].cyc) begin
                        wins[n][m]++;
                        if (wins[n][m] > 1) begin
                            report_problem($sformatf("master %0d served twice while %0d waited",
                                                     m, n));
                        end
                    end
                end
            end
            if (m_rsp[m].ack || m_rsp[m].err || !m_req[m].cyc) begin
                for (int k = 0; k < NUM_MASTERS; k++) begin
                    wins[m][k] = 0;
                end
            end
        end
    end

    initial begin
        int grp_max;
        int n_in_grp;
        int err_before;
        clk      = 1'b0;
        reset    <= 1'b1;
        lfsr_q   = 32'hfbd9;
        n_checks = 0;
        n_errors = 0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_req[m] <= '0;
        end
        load_testdata();
        loaded = 1;

        // outputs stay quiet in and after reset
        err_before = n_errors;
        for (int c = 0; c < RESET_CYCLES + 4; c++) begin
            @(posedge clk);
            for (int m = 0; m < NUM_MASTERS; m++) begin
                check_status($sformatf("m_rsp_o[%0d]", m), m_rsp[m], 3'b000);
            end
            if (c == RESET_CYCLES - 1) begin
                reset <= 1'b0;
            end
        end
        $display("reset: idle outputs, %0d errors", n_errors - err_before);

        grp_max = -1;
        for (int i = 0; i < n_tx; i++) begin
            if (tx_group[i] > grp_max) begin
                grp_max = tx_group[i];
            end
        end
        for (int g = 0; g <= grp_max; g++) begin
            n_in_grp = 0;
            for (int i = 0; i < n_tx; i++) begin
                if (tx_group[i] == g) begin
                    n_in_grp++;
                end
            end
            if (n_in_grp > 0) begin
                err_before = n_errors;
                fork
                    run_master(0, g);
                    run_master(1, g);
                    run_master(2, g);
                join
                @(posedge clk);
                $display("group %0d: %0d transactions, %0d errors", g, n_in_grp,
                         n_errors - err_before);
            end
        end
        repeat (3) @(posedge clk);  // idle tail for the monitor
        $display("checks %0d, passed %0d, failed %0d", n_checks, n_checks - n_errors, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, 50 cycles per transaction on top of reset
    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + 20 + 50 * n_tx) @(posedge clk);
        $display("timeout: transactions still pending after %0d cycles",
                 RESET_CYCLES + 20 + 50 * n_tx);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/wb_soc_testdata.txt
# group master we addr data sel exp   (hex: addr data sel, exp 0 = ack 1 = err)
# write lines carry write data, read lines carry the expected word
0 0 1 00000010 11223344 f 0
0 1 1 00001020 a5a5a5a5 f 0
0 2 1 00002030 cafef00d f 0
1 1 0 00000010 11223344 f 0
1 2 0 00001020 a5a5a5a5 f 0
1 0 0 00002030 cafef00d f 0
2 0 1 00000010 000000ee 1 0
2 1 1 00001020 5a000000 8 0
2 2 1 00002030 00beef00 6 0
3 0 0 00001020 5aa5a5a5 f 0
3 1 0 00002030 cabeef0d f 0
3 2 1 00003010 deadbeef f 1
4 0 0 00005000 00000000 f 1
4 1 0 00000010 112233ee f 0
5 0 1 00000040 0f0f0001 f 0
5 0 1 00000044 0f0f0002 f 0
5 0 1 00000048 0f0f0003 f 0
5 1 1 00001040 1e1e0011 f 0
5 1 1 00001044 1e1e0012 f 0
5 1 1 00001048 1e1e0013 f 0
5 2 1 00002040 2d2d0021 f 0
5 2 1 00002044 2d2d0022 f 0
5 2 1 00002048 2d2d0023 f 0
6 0 0 00002048 2d2d0023 f 0
6 1 0 00000044 0f0f0002 f 0
6 2 0 00001040 1e1e0011 f 0

// File: files.f
rtl/wb_pkg.sv
rtl/bus_arbiter.sv
rtl/wb_slave_decoder.sv
rtl/wishbone_bus.sv
rtl/wb_ram_slave.sv
rtl/wb_soc.sv
sim/tb_wb_soc.sv

// File: Bender.yml
package:
  name: wb_soc

sources:
  - rtl/wb_pkg.sv
  - rtl/bus_arbiter.sv
  - rtl/wb_slave_decoder.sv
  - rtl/wishbone_bus.sv
  - rtl/wb_ram_slave.sv
  - rtl/wb_soc.sv
  - target: simulation
    files:
      - sim/tb_wb_soc.sv
